// ==== sources.f ====
+incdir+include
verilog/alignPkg.sv
verilog/boundaryMarker.sv
verilog/startPicker.sv
verilog/instrAligner.sv
verilog/preDecoder.sv
verilog/fetchAlignTop.sv
testbench/tbFetchAlign.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tbFetchAlign -o simFetchAlign

# The search below decides the result, a fatal stop only ends the run
./obj_dir/simFetchAlign > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== testbench/tbFetchAlign.sv ====
`timescale 1ns/10ps
`include "align_defs.svh"

module tbFetchAlign;
    import alignPkg::*;

    localparam int pktSize = `FETCH_HALFWORDS;
    localparam int slots = `ALIGN_SLOTS;

    logic                             clk;
    logic                             arstN;
    logic                             clear;
    logic                             inValid;
    halfword_t [pktSize-1:0]          inHalfwords;
    fetchAddr_t                       inAddr;
    fetchOff_t                        inFirst;
    fetchOff_t                        inLast;
    logic                             inReady;
    logic                             outReady;
    logic [slots-1:0]                 outValid;
    instr_t [slots-1:0]               outInstr;
    pc_t [slots-1:0]                  outPc;
    logic [slots-1:0]                 outIs16;
    instrClass_t [slots-1:0]          outClass;
    pc_t [slots-1:0]                  outTarget;

    integer seed;
    integer readySeed;
    bit     backPressure = 1'b0;
    bit     blockOut = 1'b0;
    bit     gaps = 1'b0;
    int     pktSent = 0;
    int     cycles;

    // Expected instructions in program order
    instr_t expInstr[$];
    pc_t    expPc[$];
    bit     expIs16[$];

    // Packets waiting to be sent
    halfword_t [pktSize-1:0] pktHw[$];
    fetchAddr_t              pktAddr[$];
    fetchOff_t               pktFirst[$];
    fetchOff_t               pktLast[$];
    halfword_t               streamHw[$];
    pc_t                     streamPc;

    bit                 stalled = 1'b0;
    logic [slots-1:0]   holdValid;
    instr_t [slots-1:0] holdInstr;
    pc_t [slots-1:0]    holdPc;

    fetchAlignTop u_dut (
        .clk         (clk),
        .arstN       (arstN),
        .clear       (clear),
        .inValid     (inValid),
        .inHalfwords (inHalfwords),
        .inAddr      (inAddr),
        .inFirst     (inFirst),
        .inLast      (inLast),
        .inReady     (inReady),
        .outReady    (outReady),
        .outValid    (outValid),
        .outInstr    (outInstr),
        .outPc       (outPc),
        .outIs16     (outIs16),
        .outClass    (outClass),
        .outTarget   (outTarget)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkInstr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            stopRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkPc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            stopRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkClass(input string name, input instrClass_t got, input instrClass_t exp);
        if (got !== exp) begin
            stopRun($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopRun($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // Class and static target taken straight from the ISA encodings
    function automatic void refPredecode(input instr_t ins, input pc_t pc, input bit is16,
                                         output instrClass_t cls, output pc_t tgt);
        logic [20:0] off;
        bit          relative;
        cls = classPlain;
        off = '0;
        relative = 1'b0;
        if (is16) begin
            if (ins[1:0] == 2'b01 && (ins[15:13] == 3'b101 || ins[15:13] == 3'b001)) begin
                cls = classJal;
                relative = 1'b1;
                off[20:11] = {10{ins[12]}};
                off[4] = ins[11];
                off[9:8] = ins[10:9];
                off[10] = ins[8];
                off[6] = ins[7];
                off[7] = ins[6];
                off[3:1] = ins[5:3];
                off[5] = ins[2];
            end else if (ins[1:0] == 2'b01 && ins[15:14] == 2'b11) begin
                cls = classBranch;
                relative = 1'b1;
                off[20:8] = {13{ins[12]}};
                off[4:3] = ins[11:10];
                off[7:6] = ins[6:5];
                off[2:1] = ins[4:3];
                off[5] = ins[2];
            end else if (ins[1:0] == 2'b10 && ins[15:13] == 3'b100
                         && ins[11:7] != 5'd0 && ins[6:2] == 5'd0) begin
                cls = (!ins[12] && ins[11:7] == 5'd1) ? classReturn : classJalr;
            end
        end else if (ins[6:0] == 7'b1100011) begin
            cls = classBranch;
            relative = 1'b1;
            off[20:12] = {9{ins[31]}};
            off[11] = ins[7];
            off[10:5] = ins[30:25];
            off[4:1] = ins[11:8];
        end else if (ins[6:0] == 7'b1101111) begin
            cls = classJal;
            relative = 1'b1;
            off[20] = ins[31];
            off[19:12] = ins[19:12];
            off[11] = ins[20];
            off[10:1] = ins[30:21];
        end else if (ins[6:0] == 7'b1100111) begin
            cls = (ins[19:15] == 5'd1 && ins[11:7] == 5'd0) ? classReturn : classJalr;
        end
        tgt = relative ? pc + {{11{off[20]}}, off} : '0;
    endfunction

    // Mode 0 gives 32-bit only, 1 mixes sizes, 2 favours control flow
    function automatic instr_t randomInstr(input int mode);
        logic [31:0] r;
        logic [4:0]  rs;
        int          kind;
        r = $random(seed);
        rs = (r[11:7] == 5'd0) ? 5'd5 : r[11:7];
        kind = (mode == 0) ? 0 : (mode == 1) ? (r[20] ? 0 : 15) : ($random(seed) & 15);
        case (kind)
            0: return {r[31:2], 2'b11};
            1: return {r[31:7], 7'b1100011};
            2: return {r[31:7], 7'b1101111};
            3: return {r[31:7], 7'b1100111};
            4: return {r[31:20], 5'd1, 3'b000, 5'd0, 7'b1100111};
            5: return {16'h0, 3'b101, r[12:2], 2'b01};
            6: return {16'h0, 3'b001, r[12:2], 2'b01};
            7: return {16'h0, 3'b110, r[12:2], 2'b01};
            8: return {16'h0, 3'b111, r[12:2], 2'b01};
            9: return {16'h0, 4'b1000, rs, 5'd0, 2'b10};
            10: return {16'h0, 4'b1000, 5'd1, 5'd0, 2'b10};
            11: return {16'h0, 4'b1001, rs, 5'd0, 2'b10};
            default: return {16'h0, r[15:2], (r[1:0] == 2'b11) ? 2'b01 : r[1:0]};
        endcase
    endfunction

    task automatic addInstr(input instr_t ins, input bit expected);
        if (expected) begin
            expInstr.push_back(ins);
            expPc.push_back(streamPc + pc_t'(2 * streamHw.size()));
            expIs16.push_back(ins[1:0] != 2'b11);
        end
        streamHw.push_back(ins[15:0]);
        if (ins[1:0] == 2'b11 && expected) begin
            streamHw.push_back(ins[31:16]);
        end
    endtask

    // A tail straddler ends the stream with only its lower half sent
    task automatic buildStream(input pc_t startPc, input int count, input int mode,
                               input bit straddleTail);
        halfword_t [pktSize-1:0] pkt;
        int                      h0;
        int                      hLast;
        int                      h;
        streamHw.delete();
        streamPc = startPc;
        h0 = int'(startPc >> 1);
        for (int n = 0; n < count; n++) begin
            addInstr(randomInstr(mode), 1'b1);
        end
        while (straddleTail && (h0 + streamHw.size()) % pktSize != pktSize - 1) begin
            addInstr({16'h0, 14'($random(seed)), 2'b00}, 1'b1);
        end
        if (straddleTail) begin
            addInstr({$random(seed)} | 32'h3, 1'b0);
        end
        hLast = h0 + streamHw.size() - 1;
        for (int p = h0 / pktSize; p <= hLast / pktSize; p++) begin
            for (int i = 0; i < pktSize; i++) begin
                h = p * pktSize + i;
                pkt[i] = (h >= h0 && h <= hLast) ? streamHw[h - h0] : halfword_t'($random(seed));
            end
            pktHw.push_back(pkt);
            pktAddr.push_back(fetchAddr_t'(p));
            pktFirst.push_back(fetchOff_t'((p == h0 / pktSize) ? h0 % pktSize : 0));
            pktLast.push_back(fetchOff_t'((p == hLast / pktSize) ? hLast % pktSize : 7));
        end
    endtask

    task automatic sendPackets(input int count);
        bit taken;
        for (int k = 0; k < count && pktHw.size() != 0; k++) begin
            inValid = 1'b1;
            inHalfwords = pktHw.pop_front();
            inAddr = pktAddr.pop_front();
            inFirst = pktFirst.pop_front();
            inLast = pktLast.pop_front();
            pktSent++;
            taken = 1'b0;
            while (!taken) begin
                @(posedge clk);
                taken = inReady;
                @(negedge clk);
            end
            inValid = 1'b0;
            if (gaps) begin
                repeat ($unsigned($random(seed)) % 3) @(negedge clk);
            end
        end
    endtask

    task automatic waitDrain();
        while (expInstr.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    always @(posedge clk) begin : monitor
        instr_t      ei;
        pc_t         ep;
        bit          e16;
        instrClass_t ec;
        pc_t         et;
        instr_t      got;
        if (arstN) begin
            if ((outValid & (outValid + 1'b1)) != '0) begin
                stopRun($sformatf("Valid slots %b are not filled from slot 0", outValid));
            end
            if (stalled) begin
                if (outValid !== holdValid) begin
                    stopRun("outValid changed while outReady was low");
                end
                for (int s = 0; s < slots; s++) begin
                    if (holdValid[s]) begin
                        checkInstr($sformatf("outInstr[%0d] held", s), outInstr[s], holdInstr[s]);
                        checkPc($sformatf("outPc[%0d] held", s), outPc[s], holdPc[s]);
                    end
                end
            end
            for (int s = 0; s < slots; s++) begin
                if (outReady && outValid[s]) begin
                    if (expInstr.size() == 0) begin
                        stopRun("An instruction came out that was never sent");
                    end
                    ei = expInstr.pop_front();
                    ep = expPc.pop_front();
                    e16 = expIs16.pop_front();
                    got = e16 ? {16'h0, outInstr[s][15:0]} : outInstr[s];
                    refPredecode(ei, ep, e16, ec, et);
                    checkBit($sformatf("outIs16[%0d]", s), outIs16[s], e16);
                    checkInstr($sformatf("outInstr[%0d]", s), got, ei);
                    checkPc($sformatf("outPc[%0d]", s), outPc[s], ep);
                    checkClass($sformatf("outClass[%0d]", s), outClass[s], ec);
                    checkPc($sformatf("outTarget[%0d]", s), outTarget[s], et);
                end
            end
            stalled = outValid[0] && !outReady;
            holdValid = outValid;
            holdInstr = outInstr;
            holdPc = outPc;
        end
    end

    initial begin
        readySeed = 32'h5a947cb4;
        outReady = 1'b1;
        forever begin
            @(negedge clk);
            if (blockOut) begin
                outReady = 1'b0;
            end else begin
                outReady = backPressure ? (($random(readySeed) & 3) != 0) : 1'b1;
            end
        end
    end

    // Limit grows with every packet handed to the DUT
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 40 * pktSent + 200) begin
                stopRun("Timeout, expected instructions stopped coming out");
            end
        end
    end

    initial begin
        seed = 32'h5a947cb4;
        arstN = 1'b0;
        clear = 1'b0;
        inValid = 1'b0;
        inHalfwords = '0;
        inAddr = '0;
        inFirst = '0;
        inLast = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        buildStream(32'h1000, 40, 0, 1'b0);
        sendPackets(1000);
        waitDrain();

        // Straddlers, a dropped tail half and a jump target
        buildStream(32'h2000, 60, 1, 1'b1);
        buildStream(32'h3006, 50, 1, 1'b0);
        sendPackets(1000);
        waitDrain();

        backPressure = 1'b1;
        gaps = 1'b1;
        buildStream(32'h4000, 120, 1, 1'b0);
        buildStream(32'h500a, 60, 2, 1'b1);
        buildStream(32'h6002, 40, 1, 1'b0);
        sendPackets(1000);
        waitDrain();

        buildStream(32'h9004, 80, 2, 1'b0);
        sendPackets(1000);
        waitDrain();

        // Flush in the middle of a stream
        backPressure = 1'b0;
        gaps = 1'b0;
        // Consumer stalls so the flush meets a held output and a loaded buffer
        blockOut = 1'b1;
        @(negedge clk);
        buildStream(32'h7000, 60, 1, 1'b0);
        sendPackets(2);
        repeat (2) @(negedge clk);
        @(posedge clk);
        blockOut = 1'b0;
        @(negedge clk);
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        expInstr.delete();
        expPc.delete();
        expIs16.delete();
        pktHw.delete();
        pktAddr.delete();
        pktFirst.delete();
        pktLast.delete();
        if (outValid !== '0) begin
            stopRun("outValid is not zero in the cycle after clear");
        end
        buildStream(32'h8000, 30, 2, 1'b0);
        sendPackets(1000);
        waitDrain();

        if (expInstr.size() != 0) begin
            stopRun("Some expected instructions never came out");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog/fetchAlignTop.sv ====
`timescale 1ns/10ps
`include "align_defs.svh"

module fetchAlignTop (
    input  logic                                       clk,
    input  logic                                       arstN,
    input  logic                                       clear,
    input  logic                                       inValid,
    input  alignPkg::halfword_t [`FETCH_HALFWORDS-1:0] inHalfwords,
    input  alignPkg::fetchAddr_t                       inAddr,
    input  alignPkg::fetchOff_t                        inFirst,
    input  alignPkg::fetchOff_t                        inLast,
    output logic                                       inReady,
    input  logic                                       outReady,
    output logic [`ALIGN_SLOTS-1:0]                    outValid,
    output alignPkg::instr_t [`ALIGN_SLOTS-1:0]        outInstr,
    output alignPkg::pc_t [`ALIGN_SLOTS-1:0]           outPc,
    output logic [`ALIGN_SLOTS-1:0]                    outIs16,
    output alignPkg::instrClass_t [`ALIGN_SLOTS-1:0]   outClass,
    output alignPkg::pc_t [`ALIGN_SLOTS-1:0]           outTarget
);

    instrAligner u_aligner (
        .clk         (clk),
        .arstN       (arstN),
        .clear       (clear),
        .inValid     (inValid),
        .inHalfwords (inHalfwords),
        .inAddr      (inAddr),
        .inFirst     (inFirst),
        .inLast      (inLast),
        .inReady     (inReady),
        .outReady    (outReady),
        .alignValid  (outValid),
        .alignInstr  (outInstr),
        .alignPc     (outPc),
        .alignIs16   (outIs16)
    );

    // Predecode works on the registered slots
    for (genvar s = 0; s < `ALIGN_SLOTS; s++) begin : gSlot
        preDecoder u_preDec (
            .instr      (outInstr[s]),
            .pc         (outPc[s]),
            .is16       (outIs16[s]),
            .instrClass (outClass[s]),
            .target     (outTarget[s])
        );
    end

endmodule

// ==== verilog/preDecoder.sv ====
`timescale 1ns/10ps

module preDecoder (
    input  alignPkg::instr_t      instr,
    input  alignPkg::pc_t         pc,
    input  logic                  is16,
    output alignPkg::instrClass_t instrClass,
    output alignPkg::pc_t         target
);
    import alignPkg::*;

    pc_t immB;
    pc_t immJ;
    pc_t immCj;
    pc_t immCb;
    pc_t imm;

    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] cRs1;
    logic [4:0] cRs2;
    logic [2:0] cFunct3;

    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign cRs1 = instr[11:7];
    assign cRs2 = instr[6:2];
    assign cFunct3 = instr[15:13];

    // Sign-extended offsets of the 32-bit and compressed jump forms
    assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immCj = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7], instr[2],
                    instr[11], instr[5:3], 1'b0};
    assign immCb = {{24{instr[12]}}, instr[6:5], instr[2], instr[11:10], instr[4:3], 1'b0};

    always_comb begin
        instrClass = classPlain;
        imm = '0;
        if (is16) begin
            if (instr[1:0] == 2'b01 && (cFunct3 == 3'b101 || cFunct3 == 3'b001)) begin
                // c.j and c.jal
                instrClass = classJal;
                imm = immCj;
            end else if (instr[1:0] == 2'b01 && cFunct3[2:1] == 2'b11) begin
                instrClass = classBranch;
                imm = immCb;
            end else if (instr[1:0] == 2'b10 && cFunct3 == 3'b100 && cRs1 != '0 && cRs2 == '0) begin
                // c.jr x1 is the compressed return
                if (!instr[12] && cRs1 == 5'd1) begin
                    instrClass = classReturn;
                end else begin
                    instrClass = classJalr;
                end
            end
        end else begin
            case (instr[6:0])
                7'b1100011: begin
                    instrClass = classBranch;
                    imm = immB;
                end
                7'b1101111: begin
                    instrClass = classJal;
                    imm = immJ;
                end
                7'b1100111: instrClass = (rs1 == 5'd1 && rd == 5'd0) ? classReturn : classJalr;
                default: instrClass = classPlain;
            endcase
        end
    end

    // Only pc-relative forms have a static target
    assign target = (instrClass == classBranch || instrClass == classJal) ? pc + imm : '0;

endmodule

// ==== verilog/instrAligner.sv ====
`timescale 1ns/10ps
`include "align_defs.svh"

module instrAligner (
    input  logic                                       clk,
    input  logic                                       arstN,
    input  logic                                       clear,
    input  logic                                       inValid,
    input  alignPkg::halfword_t [`FETCH_HALFWORDS-1:0] inHalfwords,
    input  alignPkg::fetchAddr_t                       inAddr,
    input  alignPkg::fetchOff_t                        inFirst,
    input  alignPkg::fetchOff_t                        inLast,
    output logic                                       inReady,
    input  logic                                       outReady,
    output logic [`ALIGN_SLOTS-1:0]                    alignValid,
    output alignPkg::instr_t [`ALIGN_SLOTS-1:0]        alignInstr,
    output alignPkg::pc_t [`ALIGN_SLOTS-1:0]           alignPc,
    output logic [`ALIGN_SLOTS-1:0]                    alignIs16
);
    import alignPkg::*;

    localparam int pktSize = `FETCH_HALFWORDS;
    localparam int winSize = `ALIGN_WINDOW;
    localparam int midLast = `BUF_PACKETS * `FETCH_HALFWORDS - 1;

    // Buffered packets, index 0 is the oldest
    halfword_t [`BUF_PACKETS-1:0][pktSize-1:0] bufHw;
    fetchAddr_t [`BUF_PACKETS-1:0]             bufAddr;
    logic [`BUF_PACKETS-1:0][pktSize-1:0]      bufStart;
    logic [`BUF_PACKETS-1:0][pktSize-1:0]      bufStart32;

    logic [pktSize-1:0] inStart;
    logic [pktSize-1:0] inStart32;
    logic               carry32;
    logic               newStream;

    // One spare zero halfword above the window
    halfword_t [winSize:0]        winHw;
    fetchAddr_t [`BUF_PACKETS:0]  winAddr;
    logic [winSize-1:0]           rawStart;
    logic [winSize-1:0]           winStart32;
    logic [winSize-1:0]           visStart;
    logic [winSize-1:0]           keep;

    windowIdx_t [`ALIGN_SLOTS-1:0] pickIdx;
    logic [`ALIGN_SLOTS-1:0]       pickValid;
    instr_t [`ALIGN_SLOTS-1:0]     pickInstr;
    pc_t [`ALIGN_SLOTS-1:0]        pickPc;
    logic [`ALIGN_SLOTS-1:0]       pickIs16;
    halfword_t                     upperHw;

    logic loadOut;
    logic accept;

    // Newest buffered packet ends in an open 32-bit half
    assign carry32 = bufStart[`BUF_PACKETS-1][pktSize-1] && bufStart32[`BUF_PACKETS-1][pktSize-1];
    assign newStream = inValid && (inFirst != '0);

    boundaryMarker u_marker (
        .halfwords (inHalfwords),
        .first     (inFirst),
        .last      (inLast),
        .valid     (inValid),
        .carry32   (carry32),
        .starts    (inStart),
        .starts32  (inStart32)
    );

    always_comb begin
        winHw = '0;
        for (int p = 0; p < `BUF_PACKETS; p++) begin
            winHw[p*pktSize +: pktSize] = bufHw[p];
            winAddr[p] = bufAddr[p];
        end
        winHw[`BUF_PACKETS*pktSize +: pktSize] = inHalfwords;
        winAddr[`BUF_PACKETS] = inAddr;
    end

    assign rawStart = {inStart, bufStart};
    assign winStart32 = {inStart32, bufStart32};

    // Hide 32-bit starts whose upper half is not in the window
    always_comb begin
        visStart = rawStart;
        visStart[winSize-1] = rawStart[winSize-1] && !winStart32[winSize-1];
        if (carry32 && (!inValid || newStream)) begin
            visStart[midLast] = 1'b0;
        end
    end

    startPicker u_picker (
        .starts   (visStart),
        .idx      (pickIdx),
        .idxValid (pickValid)
    );

    always_comb begin
        upperHw = '0;
        for (int s = 0; s < `ALIGN_SLOTS; s++) begin
            pickIs16[s] = !winStart32[pickIdx[s]];
            upperHw = pickIs16[s] ? 16'h0 : winHw[pickIdx[s] + 1];
            pickInstr[s] = {upperHw, winHw[pickIdx[s]]};
            // Owning packet base, then halfword offset as byte address
            pickPc[s] = {winAddr[pickIdx[s] / pktSize], fetchOff_t'(pickIdx[s] % pktSize), 1'b0};
        end
    end

    assign loadOut = !alignValid[0] || outReady;

    // Starts that survive this cycle
    always_comb begin
        for (int i = 0; i < winSize; i++) begin
            keep[i] = !loadOut || (pickValid[`ALIGN_SLOTS-1] && (i > pickIdx[`ALIGN_SLOTS-1]));
        end
        keep[winSize-1] = keep[winSize-1] || winStart32[winSize-1];
        // Pending half waits for its packet, unless a jump target starts a new stream
        if (carry32 && (!inValid || newStream)) begin
            keep[midLast] = !newStream;
        end
    end

    // Oldest packet can only leave once all its starts are out
    assign inReady = !(|(rawStart[0 +: pktSize] & keep[0 +: pktSize]));
    assign accept = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bufStart <= '0;
            bufStart32 <= '0;
        end else if (clear) begin
            bufStart <= '0;
            bufStart32 <= '0;
        end else if (accept) begin
            for (int p = 0; p < `BUF_PACKETS; p++) begin
                bufStart[p] <= rawStart[(p+1)*pktSize +: pktSize] & keep[(p+1)*pktSize +: pktSize];
                bufStart32[p] <= winStart32[(p+1)*pktSize +: pktSize];
            end
        end else begin
            for (int p = 0; p < `BUF_PACKETS; p++) begin
                bufStart[p] <= bufStart[p] & keep[p*pktSize +: pktSize];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int p = 0; p < `BUF_PACKETS; p++) begin
                bufHw[p] <= winHw[(p+1)*pktSize +: pktSize];
                bufAddr[p] <= winAddr[p+1];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            alignValid <= '0;
        end else if (clear) begin
            alignValid <= '0;
        end else if (loadOut) begin
            alignValid <= pickValid;
        end
    end

    always_ff @(posedge clk) begin
        if (loadOut) begin
            alignInstr <= pickInstr;
            alignPc <= pickPc;
            alignIs16 <= pickIs16;
        end
    end

endmodule

// ==== verilog/startPicker.sv ====
`timescale 1ns/10ps
`include "align_defs.svh"

module startPicker (
    input  logic [`ALIGN_WINDOW-1:0]                  starts,
    output alignPkg::windowIdx_t [`ALIGN_SLOTS-1:0] idx,
    output logic [`ALIGN_SLOTS-1:0]                   idxValid
);
    import alignPkg::*;

    logic [`ALIGN_WINDOW-1:0] remaining;

    always_comb begin
        remaining = starts;

        for (int s = 0; s < `ALIGN_SLOTS; s++) begin
            idx[s] = '0;
            idxValid[s] = 1'b0;

            // Scan from the top so the lowest set bit is the one that sticks
            for (int i = `ALIGN_WINDOW - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    idx[s] = windowIdx_t'(i);
                    idxValid[s] = 1'b1;
                end
            end

            // Remove the found start before searching for the next slot
            if (idxValid[s]) begin
                remaining[idx[s]] = 1'b0;
            end
        end
    end

endmodule

// ==== verilog/boundaryMarker.sv ====
`timescale 1ns/10ps
`include "align_defs.svh"

module boundaryMarker (
    input  alignPkg::halfword_t [`FETCH_HALFWORDS-1:0] halfwords,
    input  alignPkg::fetchOff_t                        first,
    input  alignPkg::fetchOff_t                        last,
    input  logic                                       valid,
    input  logic                                       carry32,
    output logic [`FETCH_HALFWORDS-1:0]                starts,
    output logic [`FETCH_HALFWORDS-1:0]                starts32
);
    import alignPkg::*;

    logic canStart;
    logic inRange;
    logic is32;
    logic upperMissing;

    always_comb begin
        // Offset 0 may hold the upper half of an instruction from the previous packet
        canStart = !carry32;
        inRange = 1'b0;
        is32 = 1'b0;
        upperMissing = 1'b0;

        for (int i = 0; i < `FETCH_HALFWORDS; i++) begin
            inRange = valid && (fetchOff_t'(i) >= first) && (fetchOff_t'(i) <= last);
            is32 = (halfwords[i][1:0] == 2'b11);

            // A 32-bit start cut off by a reduced last never gets its upper half
            upperMissing = is32 && (fetchOff_t'(i) == last) && (i != `FETCH_HALFWORDS - 1);

            if (inRange && canStart && !upperMissing) begin
                starts[i] = 1'b1;
                starts32[i] = is32;
                canStart = !is32;
            end else begin
                starts[i] = 1'b0;
                starts32[i] = 1'b0;
                // Either a second half or out of range, next one may start again
                canStart = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/alignPkg.sv ====
package alignPkg;

    // One instruction parcel as delivered by fetch
    typedef logic [15:0] halfword_t;

    // One aligned instruction
    // upper half is not meaningful for compressed instructions
    typedef logic [31:0] instr_t;

    // Packet base address, counted in 16-byte packets
    typedef logic [27:0] fetchAddr_t;

    // Byte program counter
    typedef logic [31:0] pc_t;

    // Halfword offset inside a packet
    typedef logic [2:0] fetchOff_t;

    // Halfword position inside the window
    typedef logic [4:0] windowIdx_t;

    // Predecode class of an instruction
    typedef logic [2:0] instrClass_t;

    // Not a control-flow instruction
    localparam instrClass_t classPlain = 3'd0;

    // Conditional branch, 32-bit or c.beqz / c.bnez
    localparam instrClass_t classBranch = 3'd1;

    // Direct jump, jal, c.j or c.jal
    localparam instrClass_t classJal = 3'd2;

    // Indirect jump through a register
    localparam instrClass_t classJalr = 3'd3;

    // jalr x0, 0(x1) and its compressed form c.jr x1
    localparam instrClass_t classReturn = 3'd4;

endpackage

// ==== include/align_defs.svh ====
`ifndef ALIGN_DEFS_SVH
`define ALIGN_DEFS_SVH

// Halfwords in one fetch packet
`define FETCH_HALFWORDS 8

// Instructions emitted per cycle
`define ALIGN_SLOTS 4

// Packets held back in the window
`define BUF_PACKETS 2

// Halfwords the start search sees, buffered packets plus the arriving one
`define ALIGN_WINDOW ((`BUF_PACKETS + 1) * `FETCH_HALFWORDS)

`endif
